/* rtl/CorePkg.sv */
package CorePkg;

    // Instruction word layout
    //   [31:25] opcode
    //   [24:21] rd
    //   [20:17] rn
    //   [16:13] rm
    //   [12:0]  immediate, zero extended

    localparam int DataWidth    = 32;
    localparam int RegCount     = 16;
    localparam int RegAddrWidth = 4;
    localparam int ShiftWidth   = 5;
    localparam int ImmWidth     = 13;

    typedef enum logic [6:0] {
        OpLslImm  = 7'd1,
        OpLsrImm  = 7'd2,
        OpAsrImm  = 7'd3,
        OpAdd     = 7'd4,
        OpSub     = 7'd5,
        OpAddImm  = 7'd6,
        OpSubImm  = 7'd7,
        OpMovImm  = 7'd8,
        OpCmpImm  = 7'd9,
        OpAnd     = 7'd12,
        OpOr      = 7'd13,
        OpLslReg  = 7'd14,
        OpLsrReg  = 7'd15,
        OpAsrReg  = 7'd16,
        OpRorReg  = 7'd19,
        OpXor     = 7'd20,
        OpCmp     = 7'd22,
        OpMovReg  = 7'd27,
        OpOutput  = 7'd69,
        OpPause   = 7'd70,
        OpInput   = 7'd71,
        OpNop     = 7'd74,
        OpHalt    = 7'd75,
        OpIllegal = 7'd127
    } OpId;

    typedef enum logic [2:0] {
        AluPassA,
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluPassB,
        AluPassShift
    } AluOp;

    typedef enum logic [1:0] {ShiftLsl, ShiftLsr, ShiftAsr, ShiftRor} ShiftOp;

    typedef enum logic [1:0] {WbNone, WbAlu, WbInput} WbSel;

    typedef enum logic [1:0] {FlagKeep, FlagShift, FlagArith, FlagLogic} FlagMode;

    typedef struct packed {
        OpId                     op;
        logic [RegAddrWidth-1:0] rd;
        logic [RegAddrWidth-1:0] rn;
        logic [RegAddrWidth-1:0] rm;
        logic [DataWidth-1:0]    offset;
    } DecodedInstr;

    typedef struct packed {
        AluOp    aluOp;
        ShiftOp  shiftOp;
        WbSel    wbSel;
        FlagMode flagMode;
        logic    useOffset;
        logic    enable;
        logic    isInput;
        logic    isOutput; // Both set means PAUSE
    } ControlWord;

endpackage

/* rtl/InstructionDecoder.sv */
`timescale 1ns/1ps

module InstructionDecoder import CorePkg::*; (
    input  logic [DataWidth-1:0] instrWord,
    output DecodedInstr          decoded
);

    logic [6:0] opcode;

    assign opcode = instrWord[31:25];

    always_comb begin
        decoded.rd     = instrWord[24:21];
        decoded.rn     = instrWord[20:17];
        decoded.rm     = instrWord[16:13];
        decoded.offset = DataWidth'(instrWord[ImmWidth-1:0]); // Zero extended

        case (opcode)
            OpLslImm,
            OpLsrImm,
            OpAsrImm,
            OpAdd,
            OpSub,
            OpAddImm,
            OpSubImm,
            OpMovImm,
            OpCmpImm,
            OpAnd,
            OpOr,
            OpLslReg,
            OpLsrReg,
            OpAsrReg,
            OpRorReg,
            OpXor,
            OpCmp,
            OpMovReg,
            OpOutput,
            OpPause,
            OpInput,
            OpNop,
            OpHalt: begin
                decoded.op = OpId'(opcode);
            end
            default: begin
                decoded.op = OpIllegal; // Memory, branch, SWI and the rest
            end
        endcase
    end

endmodule

/* rtl/ControlCore.sv */
`timescale 1ns/1ps

module ControlCore import CorePkg::*; (
    input  OpId        op,
    input  logic       confirmation,
    input  logic       continueButton,
    output ControlWord control
);

    always_comb begin
        control.aluOp     = AluPassB;
        control.shiftOp   = ShiftLsl;
        control.wbSel     = WbAlu;
        control.flagMode  = FlagKeep;
        control.useOffset = 1'b0;
        control.enable    = 1'b1;
        control.isInput   = 1'b0;
        control.isOutput  = 1'b0;

        case (op)
            OpLslImm, OpLslReg: begin
                control.aluOp     = AluPassShift;
                control.shiftOp   = ShiftLsl;
                control.flagMode  = FlagShift;
                control.useOffset = (op == OpLslImm);
            end
            OpLsrImm, OpLsrReg: begin
                control.aluOp     = AluPassShift;
                control.shiftOp   = ShiftLsr;
                control.flagMode  = FlagShift;
                control.useOffset = (op == OpLsrImm);
            end
            OpAsrImm, OpAsrReg: begin
                control.aluOp     = AluPassShift;
                control.shiftOp   = ShiftAsr;
                control.flagMode  = FlagShift;
                control.useOffset = (op == OpAsrImm);
            end
            OpRorReg: begin
                control.aluOp    = AluPassShift;
                control.shiftOp  = ShiftRor;
                control.flagMode = FlagShift;
            end
            OpAdd, OpAddImm: begin
                control.aluOp     = AluAdd;
                control.flagMode  = FlagArith;
                control.useOffset = (op == OpAddImm);
            end
            OpSub, OpSubImm: begin
                control.aluOp     = AluSub;
                control.flagMode  = FlagArith;
                control.useOffset = (op == OpSubImm);
            end
            OpMovImm: begin
                control.flagMode  = FlagLogic;
                control.useOffset = 1'b1;
            end
            OpCmp, OpCmpImm: begin
                control.aluOp     = AluSub;
                control.wbSel     = WbNone; // Flags only
                control.flagMode  = FlagArith;
                control.useOffset = (op == OpCmpImm);
            end
            OpAnd: begin
                control.aluOp    = AluAnd;
                control.flagMode = FlagLogic;
            end
            OpOr: begin
                control.aluOp    = AluOr;
                control.flagMode = FlagLogic;
            end
            OpXor: begin
                control.aluOp    = AluXor;
                control.flagMode = FlagLogic;
            end
            OpMovReg: begin
                control.flagMode = FlagLogic;
            end
            OpOutput: begin
                control.aluOp    = AluPassA;
                control.wbSel    = WbNone;
                control.enable   = confirmation; // outReady
                control.isOutput = 1'b1;
            end
            OpPause: begin
                control.wbSel    = WbNone;
                control.enable   = continueButton;
                control.isInput  = 1'b1;
                control.isOutput = 1'b1;
            end
            OpInput: begin
                control.aluOp   = AluPassA;
                control.wbSel   = WbInput;
                control.enable  = confirmation; // inValid
                control.isInput = 1'b1;
            end
            OpNop: begin
                control.wbSel = WbNone;
            end
            OpHalt: begin
                control.wbSel  = WbNone;
                control.enable = 1'b0; // Never retires
            end
            default: control.wbSel = WbNone;
        endcase
    end

endmodule

/* rtl/RegisterBank.sv */
`timescale 1ns/1ps

module RegisterBank import CorePkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [RegAddrWidth-1:0] readAddrA,
    input  logic [RegAddrWidth-1:0] readAddrB,
    input  logic                    writeEn,
    input  logic [RegAddrWidth-1:0] writeAddr,
    input  logic [DataWidth-1:0]    writeData,
    output logic [DataWidth-1:0]    readDataA,
    output logic [DataWidth-1:0]    readDataB
);

    logic [DataWidth-1:0] regs [RegCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous reads, the write shows up on the next instruction
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

/* rtl/BarrelShifter.sv */
`timescale 1ns/1ps

module BarrelShifter import CorePkg::*; (
    input  logic [DataWidth-1:0]  value,
    input  logic [ShiftWidth-1:0] amount,
    input  ShiftOp                shiftOp,
    output logic [DataWidth-1:0]  result,
    output logic                  carryOut
);

    logic [2*DataWidth-1:0]  doubled;
    logic [ShiftWidth-1:0]   lslIndex;
    logic [ShiftWidth-1:0]   rightIndex;

    assign doubled    = {value, value} >> amount;         // Rotate source
    assign lslIndex   = ShiftWidth'(DataWidth) - amount;  // Wraps to 32 - amount
    assign rightIndex = amount - 1'b1;

    always_comb begin
        case (shiftOp)
            ShiftLsl: result = value << amount;
            ShiftLsr: result = value >> amount;
            ShiftAsr: result = DataWidth'($signed(value) >>> amount);
            default:  result = doubled[DataWidth-1:0];
        endcase

        if (amount == '0) begin
            carryOut = 1'b0;
        end else if (shiftOp == ShiftLsl) begin
            carryOut = value[lslIndex];
        end else begin
            carryOut = value[rightIndex]; // Same bit for LSR, ASR and ROR
        end
    end

endmodule

/* rtl/Alu.sv */
`timescale 1ns/1ps

module Alu import CorePkg::*; (
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  logic [DataWidth-1:0] shifted,
    input  logic                 shiftCarry,
    input  AluOp                 aluOp,
    output logic [DataWidth-1:0] result,
    output logic [3:0]           nzcv
);

    logic                 subtract;
    logic [DataWidth-1:0] bOperand;
    logic [DataWidth:0]   sum;
    logic                 overflow;

    // One adder serves ADD and SUB, carry out doubles as not-borrow
    assign subtract = (aluOp == AluSub);
    assign bOperand = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, bOperand} + (DataWidth + 1)'(subtract);
    assign overflow = (a[DataWidth-1] == bOperand[DataWidth-1])
                   && (sum[DataWidth-1] != a[DataWidth-1]);

    always_comb begin
        nzcv[1:0] = 2'b00; // C and V unused by logic ops
        case (aluOp)
            AluPassA:     result = a;
            AluAdd, AluSub: begin
                result  = sum[DataWidth-1:0];
                nzcv[1] = sum[DataWidth];
                nzcv[0] = overflow;
            end
            AluAnd:       result = a & b;
            AluOr:        result = a | b;
            AluXor:       result = a ^ b;
            AluPassShift: begin
                result  = shifted;
                nzcv[1] = shiftCarry;
            end
            default:      result = b; // AluPassB
        endcase

        nzcv[3] = result[DataWidth-1];
        nzcv[2] = (result == '0);
    end

endmodule

/* rtl/StatusRegister.sv */
`timescale 1ns/1ps

module StatusRegister import CorePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       retire,
    input  logic       haltSeen,
    input  FlagMode    flagMode,
    input  logic [3:0] nzcv,
    output logic [3:0] flags,
    output logic       halted
);

    always_ff @(posedge clk) begin
        if (reset) begin
            flags  <= 4'b0000;
            halted <= 1'b0;
        end else begin
            if (haltSeen) begin
                halted <= 1'b1; // Sticky until reset
            end
            if (retire) begin
                case (flagMode)
                    FlagArith: flags      <= nzcv;
                    FlagLogic: flags[3:2] <= nzcv[3:2];
                    FlagShift: flags[3:1] <= nzcv[3:1];
                    default:   flags      <= flags;
                endcase
            end
        end
    end

endmodule

/* rtl/ExecCore.sv */
`timescale 1ns/1ps

module ExecCore import CorePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instrValid,
    output logic                 instrReady,
    input  logic [DataWidth-1:0] instrWord,
    output logic                 outValid,
    input  logic                 outReady,
    output logic [DataWidth-1:0] outData,
    input  logic                 inValid,
    output logic                 inReady,
    input  logic [DataWidth-1:0] inData,
    input  logic                 continueButton,
    output logic                 paused,
    output logic                 halted,
    output logic [3:0]           flags
);

    DecodedInstr          decoded;
    ControlWord           control;
    logic                 confirmation;
    logic [DataWidth-1:0] rnValue;
    logic [DataWidth-1:0] rmValue;
    logic [DataWidth-1:0] bChannel;
    logic [DataWidth-1:0] shiftResult;
    logic                 shiftCarry;
    logic [DataWidth-1:0] aluResult;
    logic [3:0]           aluNzcv;
    logic [3:0]           flagCandidate;
    logic                 retire;
    logic                 haltSeen;
    logic [DataWidth-1:0] writeData;

    InstructionDecoder decoder (.instrWord(instrWord), .decoded(decoded));

    // Picked from the opcode so enable does not loop back through control
    assign confirmation = (decoded.op == OpOutput) ? outReady : inValid;

    ControlCore controlCore (
        .op(decoded.op),
        .confirmation(confirmation),
        .continueButton(continueButton),
        .control(control)
    );

    assign instrReady = control.enable & ~halted;
    assign retire     = instrValid & instrReady;
    assign haltSeen   = instrValid & (decoded.op == OpHalt);

    assign outValid = instrValid & control.isOutput & ~control.isInput & ~halted;
    assign inReady  = instrValid & control.isInput & ~control.isOutput & ~halted;
    assign paused   = instrValid & control.isInput & control.isOutput & ~halted;
    assign outData  = rnValue;

    assign bChannel  = control.useOffset ? decoded.offset : rmValue;
    assign writeData = (control.wbSel == WbInput) ? inData : aluResult;

    RegisterBank registerBank (
        .clk(clk),
        .reset(reset),
        .readAddrA(decoded.rn),
        .readAddrB(decoded.rm),
        .writeEn(retire && control.wbSel != WbNone),
        .writeAddr(decoded.rd),
        .writeData(writeData),
        .readDataA(rnValue),
        .readDataB(rmValue)
    );

    BarrelShifter shifter (
        .value(rnValue),
        .amount(bChannel[ShiftWidth-1:0]),
        .shiftOp(control.shiftOp),
        .result(shiftResult),
        .carryOut(shiftCarry)
    );

    Alu alu (
        .a(rnValue),
        .b(bChannel),
        .shifted(shiftResult),
        .shiftCarry(shiftCarry),
        .aluOp(control.aluOp),
        .result(aluResult),
        .nzcv(aluNzcv)
    );

    // Zero shift amount keeps the old carry
    always_comb begin
        flagCandidate = aluNzcv;
        if (control.flagMode == FlagShift && bChannel[ShiftWidth-1:0] == '0) begin
            flagCandidate[1] = flags[1];
        end
    end

    StatusRegister statusRegister (
        .clk(clk),
        .reset(reset),
        .retire(retire),
        .haltSeen(haltSeen),
        .flagMode(control.flagMode),
        .nzcv(flagCandidate),
        .flags(flags),
        .halted(halted)
    );

endmodule

/* tests/ExecCore_props.sv */
`timescale 1ns/1ps

module ExecCoreProps import CorePkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic                 instrValid,
    input logic                 instrReady,
    input logic [DataWidth-1:0] instrWord,
    input logic                 outValid,
    input logic                 outReady,
    input logic [DataWidth-1:0] outData,
    input logic                 halted,
    input logic [3:0]           flags
);

    outHeld: assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("outValid dropped or outData changed before outReady");

    // A waiting instruction changes nothing
    waitStable: assert property (@(posedge clk) disable iff (reset)
        instrValid && !instrReady && !halted
        |=> instrValid && $stable(instrWord) && $stable(flags) && $stable(outData))
        else $error("state changed while the instruction was waiting");

    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind ExecCore ExecCoreProps props (.*);

/* tests/ExecCoreTb.sv */
`timescale 1ns/1ps

module ExecCoreTb import CorePkg::*; #(
    parameter int Seed = 81
) ();

    localparam int ClkPeriod  = 100;
    localparam int MaxStall   = 3;
    localparam int NumRandom  = 60;
    localparam int TotalInstr = RegCount * 2 + NumRandom * 2 + 7 * 4 * 3 + 20;
    localparam int TimeoutNs  = (TotalInstr * (MaxStall + 3) + 40) * ClkPeriod;

    typedef struct packed {
        logic                 wr;
        logic [DataWidth-1:0] data;
        logic [3:0]           nzcv;
        logic [DataWidth-1:0] outData;
    } Expect;

    logic                 clk;
    logic                 reset;
    logic                 instrValid;
    logic                 instrReady;
    logic [DataWidth-1:0] instrWord;
    logic                 outValid;
    logic                 outReady;
    logic [DataWidth-1:0] outData;
    logic                 inValid;
    logic                 inReady;
    logic [DataWidth-1:0] inData;
    logic                 continueButton;
    logic                 paused;
    logic                 halted;
    logic [3:0]           flags;

    int unsigned          rngState = Seed;
    int unsigned          outputsIssued = 0;
    int unsigned          outputsSeen = 0;
    logic [DataWidth-1:0] modelRegs [RegCount];
    logic [3:0]           modelFlags;
    logic                 flagsPending;
    Expect                expected;

    logic [6:0] aluOps [11] = '{OpAdd, OpSub, OpAddImm, OpSubImm, OpMovImm, OpMovReg,
                                OpAnd, OpOr, OpXor, OpCmp, OpCmpImm};
    logic [6:0] shiftOps [7] = '{OpLslImm, OpLsrImm, OpAsrImm, OpLslReg, OpLsrReg,
                                 OpAsrReg, OpRorReg};
    logic [6:0] illegalOps [5] = '{7'd10, 7'd11, 7'd30, 7'd100, 7'd126};

    ExecCore uut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic int unsigned nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState >> 8;
    endfunction

    function automatic logic [DataWidth-1:0] encode(input logic [6:0] op, input logic [3:0] rd,
            input logic [3:0] rn, input logic [3:0] rm, input logic [12:0] imm);
        return {op, rd, rn, rm, imm};
    endfunction

    // Expected effect of one retiring instruction on the register and flag model
    function automatic Expect refExec(input logic [DataWidth-1:0] word,
            input logic [DataWidth-1:0] inVal);
        Expect                e;
        logic [6:0]           op;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [DataWidth-1:0] r;
        logic [DataWidth:0]   wide;
        logic [4:0]           amt;
        logic [4:0]           lslBit;
        logic                 c;
        logic                 v;
        logic                 update;
        op = word[31:25];
        a = modelRegs[word[20:17]];
        b = modelRegs[word[16:13]];
        if (op inside {OpLslImm, OpLsrImm, OpAsrImm, OpAddImm, OpSubImm, OpMovImm, OpCmpImm}) begin
            b = DataWidth'(word[12:0]);
        end
        amt = b[4:0];
        lslBit = 5'd0 - amt; // Bit 32 - amt
        r = b;
        c = modelFlags[1];
        v = modelFlags[0];
        update = 1'b1;
        e.wr = 1'b1;
        e.outData = a;
        case (op)
            OpLslImm, OpLslReg: begin
                r = a << amt;
                if (amt != 0) c = a[lslBit];
            end
            OpLsrImm, OpLsrReg: begin
                r = a >> amt;
                if (amt != 0) c = a[amt - 5'd1];
            end
            OpAsrImm, OpAsrReg: begin
                r = $signed(a) >>> amt;
                if (amt != 0) c = a[amt - 5'd1];
            end
            OpRorReg: begin
                r = (a >> amt) | (a << (6'd32 - {1'b0, amt}));
                if (amt != 0) c = a[amt - 5'd1];
            end
            OpAdd, OpAddImm: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[DataWidth-1:0];
                c = wide[DataWidth];
                v = (a[31] == b[31]) && (r[31] != a[31]);
            end
            OpSub, OpSubImm, OpCmp, OpCmpImm: begin
                r = a - b;
                c = (a >= b); // No borrow
                v = (a[31] != b[31]) && (r[31] != a[31]);
                e.wr = !(op inside {OpCmp, OpCmpImm});
            end
            OpAnd: r = a & b;
            OpOr: r = a | b;
            OpXor: r = a ^ b;
            OpMovImm, OpMovReg: r = b;
            OpInput: update = 1'b0;
            default: begin
                update = 1'b0;
                e.wr = 1'b0;
            end
        endcase
        e.data = (op == OpInput) ? inVal : r;
        e.nzcv = update ? {r[31], r == '0, c, v} : modelFlags;
        return e;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] want, input string what);
        if (actual !== want) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, want);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // Present one instruction, stall its I/O answer for a random count, wait for retirement
    task automatic runInstr(input logic [DataWidth-1:0] word);
        logic [6:0]  op;
        int unsigned stall;
        op = word[31:25];
        stall = 0;
        if (op == OpPause) begin
            stall = 1 + nextRand() % MaxStall;
        end else if (op == OpOutput || op == OpInput) begin
            stall = nextRand() % (MaxStall + 1);
        end
        if (op == OpOutput) outputsIssued++;
        instrWord = word;
        instrValid = 1'b1;
        inData = nextRand();
        // Only the answer this op waits for is held back
        outReady = !(op == OpOutput && stall != 0);
        inValid = !(op == OpInput && stall != 0);
        continueButton = !(op == OpPause && stall != 0);
        repeat (stall) begin
            @(negedge clk);
            check(32'(instrReady), 0, "instrReady while stalled");
            @(posedge clk);
            #1;
        end
        outReady = 1'b1;
        inValid = 1'b1;
        continueButton = 1'b1;
        do @(negedge clk); while (!instrReady);
        @(posedge clk);
        #1;
        instrValid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) modelRegs[i] = '0;
            modelFlags = 4'b0000;
            flagsPending = 1'b0;
        end else begin
            if (flagsPending) begin
                check(32'(flags), 32'(modelFlags), "flags after retirement");
                flagsPending = 1'b0;
            end
            if (instrValid && !halted) begin
                check(32'({outValid, inReady, paused}),
                      32'({instrWord[31:25] == OpOutput, instrWord[31:25] == OpInput,
                           instrWord[31:25] == OpPause}), "I/O request lines");
            end
            if (outValid && outReady) outputsSeen++;
            if (instrValid && instrReady) begin
                expected = refExec(instrWord, inData);
                if (instrWord[31:25] == OpOutput) begin
                    check(32'(outValid && outReady), 1, "output transfer at retirement");
                    check(outData, expected.outData, "outData");
                end
                if (instrWord[31:25] == OpInput) begin
                    check(32'(inReady && inValid), 1, "input transfer at retirement");
                end
                if (expected.wr) modelRegs[instrWord[24:21]] = expected.data;
                modelFlags = expected.nzcv;
                flagsPending = 1'b1;
            end
        end
    end

    initial begin
        #(TimeoutNs);
        $display("timeout: the run did not finish within %0d ns", TimeoutNs);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [3:0] rd;
        logic [3:0] rn;
        logic [4:0] amt;
        logic [6:0] op;
        reset = 1'b1;
        instrValid = 1'b0;
        instrWord = '0;
        outReady = 1'b0;
        inValid = 1'b0;
        inData = '0;
        continueButton = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check(32'({outValid, inReady, paused, halted, flags}), 0, "outputs after reset");
        @(posedge clk);
        #1;

        for (int i = 0; i < RegCount; i++) begin
            runInstr(encode(OpInput, 4'(i), 4'd0, 4'd0, 13'd0)); // Load every register
        end

        for (int n = 0; n < NumRandom; n++) begin
            rd = 4'(nextRand());
            op = aluOps[nextRand() % 11];
            runInstr(encode(op, rd, 4'(nextRand()), 4'(nextRand()), 13'(nextRand())));
            runInstr(encode(OpOutput, 4'd0, rd, 4'd0, 13'd0));
        end

        for (int s = 0; s < 7; s++) begin
            for (int k = 0; k < 4; k++) begin
                amt = (k == 0) ? 5'd0 : (k == 1) ? 5'd1 : (k == 2) ? 5'd31 : 5'(nextRand());
                rd = 4'(nextRand() % 15);
                rn = 4'(nextRand() % 15);
                op = shiftOps[s];
                if (op inside {OpLslImm, OpLsrImm, OpAsrImm}) begin
                    runInstr(encode(op, rd, rn, 4'd0, {8'(nextRand()), amt})); // Upper bits ignored
                end else begin
                    runInstr(encode(OpMovImm, 4'd15, 4'd0, 4'd0, 13'(amt)));
                    runInstr(encode(op, rd, rn, 4'd15, 13'd0));
                end
                runInstr(encode(OpOutput, 4'd0, rd, 4'd0, 13'd0));
            end
        end

        for (int n = 0; n < 4; n++) runInstr(encode(OpPause, 4'd0, 4'd0, 4'd0, 13'd0));
        for (int n = 0; n < 5; n++) begin
            runInstr(encode(illegalOps[n], 4'(nextRand()), 4'(nextRand()), 4'd0, 13'(nextRand())));
        end
        runInstr(encode(OpNop, 4'(nextRand()), 4'd0, 4'd0, 13'd0));
        for (int i = 0; i < RegCount; i++) begin
            runInstr(encode(OpOutput, 4'd0, 4'(i), 4'd0, 13'd0));
        end

        instrWord = encode(OpHalt, 4'd0, 4'd0, 4'd0, 13'd0);
        instrValid = 1'b1;
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check(32'(halted), 1, "halted after HALT");
            check(32'(instrReady), 0, "instrReady after HALT");
        end
        check(outputsSeen, outputsIssued, "output transfer count");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* build.f */
rtl/CorePkg.sv
rtl/InstructionDecoder.sv
rtl/ControlCore.sv
rtl/RegisterBank.sv
rtl/BarrelShifter.sv
rtl/Alu.sv
rtl/StatusRegister.sv
rtl/ExecCore.sv
tests/ExecCore_props.sv
tests/ExecCoreTb.sv

/* Makefile */
# Verilator build and run for the ExecCore testbench
TOP    ?= ExecCoreTb
SEED   ?= 81
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM    := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) --Mdir $(OBJDIR) -f build.f

# The run passes only when the pass line shows up in the simulator output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)
